// File: hdl/bpu_pkg.sv
`default_nettype none

package bpu_pkg;

    // address and data widths
    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [7:0]  apb_addr_t;

    // table indexes and tags, cut from the fetch block address
    typedef logic [3:0]  ubtb_idx_t;   // pc[7:4]
    typedef logic [9:0]  ubtb_tag_t;   // pc[17:8]
    typedef logic [5:0]  btb_idx_t;    // pc[9:4]
    typedef logic [7:0]  btb_tag_t;    // pc[17:10]
    typedef logic [7:0]  bim_idx_t;    // pc[11:4]

    // two-bit saturating counter, taken at 2 or 3
    typedef logic [1:0]  ctr_t;

    // instruction slot of the branch inside its block
    typedef logic [1:0]  slot_off_t;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } csr_state_t;

    localparam vaddr_t FETCH_BYTES = 32'd16;
    localparam vaddr_t RESET_PC    = 32'h0000_1000;

    localparam int UBTB_ENTRIES = 16;
    localparam int BTB_ENTRIES  = 64;
    localparam int BIM_ENTRIES  = 256;

    // weakly not-taken
    localparam ctr_t CTR_RESET = 2'd1;
    localparam ctr_t CTR_MIN   = 2'd0;
    localparam ctr_t CTR_MAX   = 2'd3;

    // register offsets
    localparam apb_addr_t CSR_CTRL      = 8'h00;
    localparam apb_addr_t CSR_START_PC  = 8'h04;
    localparam apb_addr_t CSR_PRED_CNT  = 8'h08;
    localparam apb_addr_t CSR_REDIR_CNT = 8'h0C;

endpackage

`default_nettype wire

// File: hdl/bpu_ubtb.sv
`default_nettype none
`timescale 1ns/1ps

module bpu_ubtb (
    input  wire              clk,
    input  wire              rst,

    input  bpu_pkg::vaddr_t  lookup_pc_i,
    output logic             hit_o,
    output bpu_pkg::vaddr_t  target_o,

    input  wire              upd_en_i,
    input  bpu_pkg::vaddr_t  upd_pc_i,
    input  bpu_pkg::vaddr_t  upd_target_i
);
    import bpu_pkg::*;

    logic [UBTB_ENTRIES-1:0] valid_q;
    ubtb_tag_t               tag_q    [UBTB_ENTRIES];
    vaddr_t                  target_q [UBTB_ENTRIES];

    ubtb_idx_t lookup_idx;
    ubtb_tag_t lookup_tag;
    ubtb_idx_t upd_idx;
    ubtb_tag_t upd_tag;

    assign lookup_idx = lookup_pc_i[7:4];
    assign lookup_tag = lookup_pc_i[17:8];
    assign upd_idx    = upd_pc_i[7:4];
    assign upd_tag    = upd_pc_i[17:8];

    // read in the same cycle, stage 1 depends on it
    assign hit_o    = valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
    assign target_o = target_q[lookup_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (upd_en_i) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_en_i) begin
            tag_q[upd_idx]    <= upd_tag;
            target_q[upd_idx] <= upd_target_i;
        end
    end

    // the pc register is reset, so stage 1 never sees an unknown hit
    a_hit_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(hit_o)
    ) else $error("ubtb hit is unknown");

endmodule

`default_nettype wire

// File: hdl/bpu_btb.sv
`default_nettype none
`timescale 1ns/1ps

module bpu_btb (
    input  wire                 clk,
    input  wire                 rst,

    input  bpu_pkg::vaddr_t     lookup_pc_i,
    output logic                hit_o,
    output bpu_pkg::slot_off_t  slot_o,
    output logic                cond_o,
    output bpu_pkg::vaddr_t     target_o,

    input  wire                 upd_en_i,
    input  bpu_pkg::vaddr_t     upd_pc_i,
    input  bpu_pkg::slot_off_t  upd_slot_i,
    input  wire                 upd_cond_i,
    input  bpu_pkg::vaddr_t     upd_target_i
);
    import bpu_pkg::*;

    logic [BTB_ENTRIES-1:0] valid_q;
    btb_tag_t               tag_q    [BTB_ENTRIES];
    slot_off_t              slot_q   [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0] cond_q;
    vaddr_t                 target_q [BTB_ENTRIES];

    btb_idx_t lookup_idx;
    btb_tag_t lookup_tag;
    btb_idx_t upd_idx;

    assign lookup_idx = lookup_pc_i[9:4];
    assign lookup_tag = lookup_pc_i[17:10];
    assign upd_idx    = upd_pc_i[9:4];

    // registered read, tag compare included
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hit_o <= 1'b0;
        end else begin
            hit_o <= valid_q[lookup_idx] && (tag_q[lookup_idx] == lookup_tag);
        end
    end

    always_ff @(posedge clk) begin
        slot_o   <= slot_q[lookup_idx];
        cond_o   <= cond_q[lookup_idx];
        target_o <= target_q[lookup_idx];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (upd_en_i) begin
            valid_q[upd_idx] <= 1'b1;
        end
    end

    // last writer wins, no replacement policy
    always_ff @(posedge clk) begin
        if (upd_en_i) begin
            tag_q[upd_idx]    <= upd_pc_i[17:10];
            slot_q[upd_idx]   <= upd_slot_i;
            cond_q[upd_idx]   <= upd_cond_i;
            target_q[upd_idx] <= upd_target_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/bpu_bimodal.sv
`default_nettype none
`timescale 1ns/1ps

module bpu_bimodal (
    input  wire              clk,
    input  wire              rst,

    input  bpu_pkg::vaddr_t  lookup_pc_i,
    output logic             taken_o,

    input  wire              upd_en_i,
    input  bpu_pkg::vaddr_t  upd_pc_i,
    input  wire              upd_taken_i
);
    import bpu_pkg::*;

    ctr_t     ctr_q [BIM_ENTRIES];
    bim_idx_t lookup_idx;
    bim_idx_t upd_idx;

    assign lookup_idx = lookup_pc_i[11:4];
    assign upd_idx    = upd_pc_i[11:4];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            taken_o <= 1'b0;
        end else begin
            // msb set means 2 or 3
            taken_o <= ctr_q[lookup_idx][1];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BIM_ENTRIES; i++) begin
                ctr_q[i] <= CTR_RESET;
            end
        end else if (upd_en_i) begin
            if (upd_taken_i && ctr_q[upd_idx] != CTR_MAX) begin
                ctr_q[upd_idx] <= ctr_q[upd_idx] + 2'd1;
            end else if (!upd_taken_i && ctr_q[upd_idx] != CTR_MIN) begin
                ctr_q[upd_idx] <= ctr_q[upd_idx] - 2'd1;
            end
        end
    end

    // an unknown index or direction would push a counter out of its range
    a_upd_known: assert property (
        @(posedge clk) disable iff (rst)
        upd_en_i |-> !$isunknown({upd_idx, upd_taken_i})
    ) else $error("bimodal update is unknown");

endmodule

`default_nettype wire

// File: hdl/bpu_s2_resolve.sv
`default_nettype none
`timescale 1ns/1ps

module bpu_s2_resolve (
    input  bpu_pkg::vaddr_t     start_pc_i,
    input  bpu_pkg::vaddr_t     s1_target_i,
    input  wire                 valid_i,

    input  wire                 btb_hit_i,
    input  bpu_pkg::slot_off_t  btb_slot_i,
    input  wire                 btb_cond_i,
    input  bpu_pkg::vaddr_t     btb_target_i,
    input  wire                 dir_taken_i,

    output bpu_pkg::vaddr_t     target_o,
    output logic                taken_o,
    output logic                override_o
);
    import bpu_pkg::*;

    vaddr_t fall_through;
    logic   slot_reached;
    logic   br_taken;

    assign fall_through = start_pc_i + FETCH_BYTES;

    // a block entered mid-way skips branches in earlier slots
    assign slot_reached = btb_slot_i >= start_pc_i[3:2];

    // unconditional branches are always taken, conditional ones follow the counter
    assign br_taken = btb_hit_i && slot_reached && (!btb_cond_i || dir_taken_i);

    assign taken_o  = br_taken;
    assign target_o = br_taken ? btb_target_i : fall_through;

    // stage 1 guessed differently
    assign override_o = valid_i && (target_o != s1_target_i);

endmodule

`default_nettype wire

// File: hdl/bpu_csr.sv
`default_nettype none
`timescale 1ns/1ps

module bpu_csr (
    input  wire                 clk,
    input  wire                 rst,

    input  wire                 psel_i,
    input  wire                 penable_i,
    input  wire                 pwrite_i,
    input  bpu_pkg::apb_addr_t  paddr_i,
    input  bpu_pkg::apb_data_t  pwdata_i,
    output bpu_pkg::apb_data_t  prdata_o,
    output logic                pready_o,
    output logic                pslverr_o,

    output logic                enable_o,
    output logic                restart_o,
    output bpu_pkg::vaddr_t     restart_pc_o,

    input  wire                 pred_evt_i,
    input  wire                 override_evt_i
);
    import bpu_pkg::*;

    csr_state_t state_q;
    csr_state_t state_d;
    logic       access;
    logic       wr_en;
    apb_data_t  pred_cnt_q;
    apb_data_t  redir_cnt_q;

    // phase of the current cycle, state_q holds the previous one
    always_comb begin
        if (!psel_i) begin
            state_d = IDLE;
        end else if (penable_i && state_q == SETUP) begin
            state_d = ACCESS;
        end else begin
            state_d = SETUP;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign access   = state_d == ACCESS;
    assign wr_en    = access && pwrite_i && !pslverr_o;
    assign pready_o = access;

    always_comb begin
        prdata_o  = '0;
        pslverr_o = 1'b0;
        if (access) begin
            case (paddr_i)
                CSR_CTRL:      prdata_o = {31'd0, enable_o};
                CSR_START_PC:  prdata_o = restart_pc_o;
                CSR_PRED_CNT: begin
                    prdata_o  = pred_cnt_q;
                    pslverr_o = pwrite_i;
                end
                CSR_REDIR_CNT: begin
                    prdata_o  = redir_cnt_q;
                    pslverr_o = pwrite_i;
                end
                default:       pslverr_o = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            enable_o     <= 1'b0;
            restart_o    <= 1'b0;
            restart_pc_o <= RESET_PC;
        end else begin
            restart_o <= wr_en && paddr_i == CSR_START_PC;
            if (wr_en && paddr_i == CSR_CTRL) begin
                enable_o <= pwdata_i[0];
            end
            if (wr_en && paddr_i == CSR_START_PC) begin
                restart_pc_o <= pwdata_i;
            end
        end
    end

    // event counters wrap
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pred_cnt_q  <= '0;
            redir_cnt_q <= '0;
        end else begin
            if (pred_evt_i) begin
                pred_cnt_q <= pred_cnt_q + 32'd1;
            end
            if (override_evt_i) begin
                redir_cnt_q <= redir_cnt_q + 32'd1;
            end
        end
    end

    a_setup_first: assert property (
        @(posedge clk) disable iff (rst)
        psel_i && penable_i |-> state_q == SETUP
    ) else $error("apb access phase without setup phase");

endmodule

`default_nettype wire

// File: hdl/branch_predictor.sv
`default_nettype none
`timescale 1ns/1ps

module branch_predictor (
    input  wire                 clk,
    input  wire                 rst,

    input  wire                 psel_i,
    input  wire                 penable_i,
    input  wire                 pwrite_i,
    input  bpu_pkg::apb_addr_t  paddr_i,
    input  bpu_pkg::apb_data_t  pwdata_i,
    output bpu_pkg::apb_data_t  prdata_o,
    output logic                pready_o,
    output logic                pslverr_o,

    input  wire                 stall_i,
    input  wire                 squash_i,
    input  bpu_pkg::vaddr_t     squash_pc_i,

    input  wire                 update_i,
    input  bpu_pkg::vaddr_t     update_pc_i,
    input  bpu_pkg::slot_off_t  update_slot_i,
    input  bpu_pkg::vaddr_t     update_target_i,
    input  wire                 update_cond_i,
    input  wire                 update_taken_i,

    output logic                pred_valid_o,
    output bpu_pkg::vaddr_t     pred_start_o,
    output bpu_pkg::vaddr_t     pred_target_o,
    output logic                pred_taken_o,
    output logic                pred_override_o
);
    import bpu_pkg::*;

    vaddr_t    pc_q;
    logic      s2_valid_q;
    vaddr_t    s2_start_q;
    vaddr_t    s2_target_q;

    logic      enable;
    logic      restart;
    vaddr_t    restart_pc;
    logic      flush;
    logic      advance;
    logic      override;

    logic      ubtb_hit;
    vaddr_t    ubtb_target;
    vaddr_t    s1_target;
    vaddr_t    s2_lookup_pc;

    logic      btb_hit;
    slot_off_t btb_slot;
    logic      btb_cond;
    vaddr_t    btb_target;
    logic      dir_taken;

    vaddr_t    s2_res_target;
    logic      s2_res_taken;
    logic      s2_res_override;

    assign flush    = restart || squash_i;
    assign advance  = enable && !stall_i;
    assign override = s2_res_override && advance && !flush;

    bpu_csr u_csr (
        .clk            (clk),
        .rst            (rst),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .prdata_o       (prdata_o),
        .pready_o       (pready_o),
        .pslverr_o      (pslverr_o),
        .enable_o       (enable),
        .restart_o      (restart),
        .restart_pc_o   (restart_pc),
        .pred_evt_i     (pred_valid_o),
        .override_evt_i (pred_override_o)
    );

    // stage 1
    bpu_ubtb u_ubtb (
        .clk          (clk),
        .rst          (rst),
        .lookup_pc_i  (pc_q),
        .hit_o        (ubtb_hit),
        .target_o     (ubtb_target),
        .upd_en_i     (update_i && update_taken_i && !update_cond_i),
        .upd_pc_i     (update_pc_i),
        .upd_target_i (update_target_i)
    );

    assign s1_target = ubtb_hit ? ubtb_target : pc_q + FETCH_BYTES;

    // while stage 2 holds, re-read its own block to keep the reads aligned
    assign s2_lookup_pc = advance ? pc_q : s2_start_q;

    bpu_btb u_btb (
        .clk          (clk),
        .rst          (rst),
        .lookup_pc_i  (s2_lookup_pc),
        .hit_o        (btb_hit),
        .slot_o       (btb_slot),
        .cond_o       (btb_cond),
        .target_o     (btb_target),
        .upd_en_i     (update_i && update_taken_i),
        .upd_pc_i     (update_pc_i),
        .upd_slot_i   (update_slot_i),
        .upd_cond_i   (update_cond_i),
        .upd_target_i (update_target_i)
    );

    bpu_bimodal u_bimodal (
        .clk         (clk),
        .rst         (rst),
        .lookup_pc_i (s2_lookup_pc),
        .taken_o     (dir_taken),
        .upd_en_i    (update_i && update_cond_i),
        .upd_pc_i    (update_pc_i),
        .upd_taken_i (update_taken_i)
    );

    bpu_s2_resolve u_s2_resolve (
        .start_pc_i   (s2_start_q),
        .s1_target_i  (s2_target_q),
        .valid_i      (s2_valid_q),
        .btb_hit_i    (btb_hit),
        .btb_slot_i   (btb_slot),
        .btb_cond_i   (btb_cond),
        .btb_target_i (btb_target),
        .dir_taken_i  (dir_taken),
        .target_o     (s2_res_target),
        .taken_o      (s2_res_taken),
        .override_o   (s2_res_override)
    );

    // next pc, restart first
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q <= RESET_PC;
        end else if (restart) begin
            pc_q <= restart_pc;
        end else if (squash_i) begin
            pc_q <= squash_pc_i;
        end else if (!advance) begin
            pc_q <= pc_q;
        end else if (override) begin
            pc_q <= s2_res_target;
        end else begin
            pc_q <= s1_target;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s2_valid_q  <= 1'b0;
            s2_start_q  <= RESET_PC;
            s2_target_q <= RESET_PC;
        end else if (flush || override) begin
            s2_valid_q <= 1'b0;
        end else if (advance) begin
            s2_valid_q  <= 1'b1;
            s2_start_q  <= pc_q;
            s2_target_q <= s1_target;
        end
    end

    // an override replaces this cycle's stage-1 block with the stage-2 one
    assign pred_valid_o    = advance && !flush;
    assign pred_override_o = override;
    assign pred_start_o    = override ? s2_start_q : pc_q;
    assign pred_target_o   = override ? s2_res_target : s1_target;
    assign pred_taken_o    = override ? s2_res_taken : ubtb_hit;

endmodule

`default_nettype wire

// File: verification/branch_predictor_tb.sv
`default_nettype none
`timescale 1ns/1ps

module branch_predictor_tb;
    import bpu_pkg::*;

    typedef enum logic [3:0] {
        OP_WRITE, OP_READ, OP_UPDATE,
        OP_SQUASH, OP_STALL, OP_EXPECT,
        OP_FILL, OP_COUNTS, OP_END
    } op_kind_t;

    // a is address or pc, b is data or target
    typedef struct packed {
        op_kind_t    kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [3:0]  f;
    } op_t;

    localparam logic [3:0] NO_FLAGS = 4'b0000;
    localparam logic [3:0] SLVERR   = 4'b0001;
    localparam logic [3:0] TAKEN    = 4'b0001;
    localparam logic [3:0] OVERRIDE = 4'b0010;
    localparam logic [3:0] COND     = 4'b0010;

    logic      clk;
    logic      rst;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    logic      stall;
    logic      squash;
    vaddr_t    squash_pc;
    logic      update;
    vaddr_t    update_pc;
    slot_off_t update_slot;
    vaddr_t    update_target;
    logic      update_cond;
    logic      update_taken;
    logic      pred_valid;
    vaddr_t    pred_start;
    vaddr_t    pred_target;
    logic      pred_taken;
    logic      pred_override;

    op_t   ops [$];
    string test_name [7];
    int    errors;
    int    checks;
    int    test_errors;
    int    tests_run;
    int    tests_failed;
    int    exp_preds;
    int    exp_overrides;
    int    cycle_limit;
    int    seed;

    // reference copy of the three tables
    logic      ref_ubtb_valid  [UBTB_ENTRIES];
    ubtb_tag_t ref_ubtb_tag    [UBTB_ENTRIES];
    vaddr_t    ref_ubtb_target [UBTB_ENTRIES];
    logic      ref_btb_valid   [BTB_ENTRIES];
    btb_tag_t  ref_btb_tag     [BTB_ENTRIES];
    logic      ref_btb_cond    [BTB_ENTRIES];
    vaddr_t    ref_btb_target  [BTB_ENTRIES];
    ctr_t      ref_bim         [BIM_ENTRIES];

    branch_predictor uut (
        .clk             (clk),
        .rst             (rst),
        .psel_i          (psel),
        .penable_i       (penable),
        .pwrite_i        (pwrite),
        .paddr_i         (paddr),
        .pwdata_i        (pwdata),
        .prdata_o        (prdata),
        .pready_o        (pready),
        .pslverr_o       (pslverr),
        .stall_i         (stall),
        .squash_i        (squash),
        .squash_pc_i     (squash_pc),
        .update_i        (update),
        .update_pc_i     (update_pc),
        .update_slot_i   (update_slot),
        .update_target_i (update_target),
        .update_cond_i   (update_cond),
        .update_taken_i  (update_taken),
        .pred_valid_o    (pred_valid),
        .pred_start_o    (pred_start),
        .pred_target_o   (pred_target),
        .pred_taken_o    (pred_taken),
        .pred_override_o (pred_override)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_addr(input string name, input vaddr_t got, input vaddr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic void reset_model();
        for (int i = 0; i < UBTB_ENTRIES; i++) begin
            ref_ubtb_valid[i] = 1'b0;
        end
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            ref_btb_valid[i] = 1'b0;
        end
        for (int i = 0; i < BIM_ENTRIES; i++) begin
            ref_bim[i] = 2'd1;
        end
    endfunction

    function automatic void model_update(input vaddr_t pc, input vaddr_t target,
                                         input logic cond, input logic taken);
        if (taken && !cond) begin
            ref_ubtb_valid[pc[7:4]]  = 1'b1;
            ref_ubtb_tag[pc[7:4]]    = pc[17:8];
            ref_ubtb_target[pc[7:4]] = target;
        end
        if (taken) begin
            ref_btb_valid[pc[9:4]]  = 1'b1;
            ref_btb_tag[pc[9:4]]    = pc[17:10];
            ref_btb_cond[pc[9:4]]   = cond;
            ref_btb_target[pc[9:4]] = target;
        end
        if (cond && taken && ref_bim[pc[11:4]] != 2'd3) begin
            ref_bim[pc[11:4]] = ref_bim[pc[11:4]] + 2'd1;
        end else if (cond && !taken && ref_bim[pc[11:4]] != 2'd0) begin
            ref_bim[pc[11:4]] = ref_bim[pc[11:4]] - 2'd1;
        end
    endfunction

    function automatic logic ubtb_hits(input vaddr_t pc);
        return ref_ubtb_valid[pc[7:4]] && ref_ubtb_tag[pc[7:4]] == pc[17:8];
    endfunction

    function automatic vaddr_t stage1_target(input vaddr_t pc);
        return ubtb_hits(pc) ? ref_ubtb_target[pc[7:4]] : pc + FETCH_BYTES;
    endfunction

    function automatic logic stage2_taken(input vaddr_t pc);
        btb_idx_t idx;
        idx = pc[9:4];
        if (!ref_btb_valid[idx] || ref_btb_tag[idx] != pc[17:10]) begin
            return 1'b0;
        end
        return !ref_btb_cond[idx] || ref_bim[pc[11:4]] >= 2'd2;
    endfunction

    function automatic vaddr_t stage2_target(input vaddr_t pc);
        return stage2_taken(pc) ? ref_btb_target[pc[9:4]] : pc + FETCH_BYTES;
    endfunction

    // fetch queue full unless a prediction is wanted
    function automatic void drive_idle();
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        stall         = 1'b1;
        squash        = 1'b0;
        squash_pc     = '0;
        update        = 1'b0;
        update_pc     = '0;
        update_slot   = '0;
        update_target = '0;
        update_cond   = 1'b0;
        update_taken  = 1'b0;
    endfunction

    task automatic begin_cycle();
        @(posedge clk);
        #2;
        drive_idle();
    endtask

    task automatic transfer_csr(input logic wr, input apb_addr_t addr,
                                input apb_data_t data, input logic err);
        begin_cycle();
        psel   = 1'b1;
        pwrite = wr;
        paddr  = addr;
        pwdata = data;
        begin_cycle();
        psel    = 1'b1;
        penable = 1'b1;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        check_bit("pready_o", pready, 1'b1);
        check_bit("pslverr_o", pslverr, err);
        if (!wr) begin
            check_data("prdata_o", prdata, data);
        end
        // restart pulse lands here
        begin_cycle();
    endtask

    task automatic send_update(input vaddr_t pc, input vaddr_t target,
                               input logic cond, input logic taken);
        begin_cycle();
        update        = 1'b1;
        update_pc     = pc;
        update_target = target;
        update_cond   = cond;
        update_taken  = taken;
        model_update(pc, target, cond, taken);
    endtask

    task automatic squash_to(input vaddr_t pc);
        begin_cycle();
        squash    = 1'b1;
        squash_pc = pc;
    endtask

    task automatic hold_stalled(input int n);
        repeat (n) begin
            begin_cycle();
            @(negedge clk);
            check_bit("pred_valid_o", pred_valid, 1'b0);
        end
    endtask

    task automatic expect_pred(input vaddr_t start, input vaddr_t target,
                               input logic taken, input logic ovr);
        begin_cycle();
        stall = 1'b0;
        @(negedge clk);
        check_bit("pred_valid_o", pred_valid, 1'b1);
        check_addr("pred_start_o", pred_start, start);
        check_addr("pred_target_o", pred_target, target);
        check_bit("pred_taken_o", pred_taken, taken);
        check_bit("pred_override_o", pred_override, ovr);
        exp_preds++;
        if (ovr) begin
            exp_overrides++;
        end
    endtask

    // random updates, then each block is replayed through both stages
    task automatic fill_random(input int n);
        vaddr_t      pcs [$];
        vaddr_t      pc;
        vaddr_t      t1;
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            pc = $random(seed) & 32'h0003_fff0;
            t1 = $random(seed) & 32'h000f_fff0;
            r  = $random(seed);
            send_update(pc, t1, r[0], r[2:1] != 2'd0);
            pcs.push_back(pc);
        end
        foreach (pcs[i]) begin
            pc = pcs[i];
            t1 = stage1_target(pc);
            squash_to(pc);
            expect_pred(pc, t1, ubtb_hits(pc), 1'b0);
            if (stage2_target(pc) != t1) begin
                expect_pred(pc, stage2_target(pc), stage2_taken(pc), 1'b1);
            end else begin
                expect_pred(t1, stage1_target(t1), ubtb_hits(t1), 1'b0);
            end
        end
    endtask

    task automatic finish_test(input int id);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %0d %s: ok", id + 1, test_name[id]);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", id + 1, test_name[id], errors - test_errors);
        end
        test_errors = errors;
    endtask

    function automatic void add_op(input op_kind_t kind, input logic [31:0] a,
                                   input logic [31:0] b, input logic [3:0] f);
        op_t o;
        o.kind = kind;
        o.a    = a;
        o.b    = b;
        o.f    = f;
        ops.push_back(o);
    endfunction

    function automatic void add_csr(input op_kind_t kind, input apb_addr_t addr,
                                    input apb_data_t data, input logic [3:0] f);
        add_op(kind, {24'd0, addr}, data, f);
    endfunction

    function automatic void build_table();
        test_name[0] = "register access";
        test_name[1] = "sequential fetch";
        test_name[2] = "ubtb training";
        test_name[3] = "btb override";
        test_name[4] = "squash and restart";
        test_name[5] = "random fill";
        test_name[6] = "event counters";

        add_csr(OP_READ, CSR_CTRL, 32'h0, NO_FLAGS);
        add_csr(OP_READ, CSR_START_PC, RESET_PC, NO_FLAGS);
        add_csr(OP_WRITE, CSR_START_PC, 32'h0000_3000, NO_FLAGS);
        add_csr(OP_READ, CSR_START_PC, 32'h0000_3000, NO_FLAGS);
        add_csr(OP_WRITE, CSR_START_PC, RESET_PC, NO_FLAGS);
        add_csr(OP_READ, CSR_START_PC, RESET_PC, NO_FLAGS);
        add_csr(OP_READ, 8'h10, 32'h0, SLVERR);
        add_csr(OP_WRITE, 8'h20, 32'hffff_ffff, SLVERR);
        add_csr(OP_WRITE, CSR_PRED_CNT, 32'h55, SLVERR);
        add_op(OP_END, 0, 0, NO_FLAGS);

        add_csr(OP_WRITE, CSR_CTRL, 32'h1, NO_FLAGS);
        add_csr(OP_READ, CSR_CTRL, 32'h1, NO_FLAGS);
        add_op(OP_EXPECT, 32'h0000_1000, 32'h0000_1010, NO_FLAGS);
        add_op(OP_EXPECT, 32'h0000_1010, 32'h0000_1020, NO_FLAGS);
        add_op(OP_STALL, 3, 0, NO_FLAGS);
        add_op(OP_EXPECT, 32'h0000_1020, 32'h0000_1030, NO_FLAGS);
        add_op(OP_END, 1, 0, NO_FLAGS);

        add_op(OP_UPDATE, 32'h0000_1100, 32'h0000_1400, TAKEN);
        add_op(OP_SQUASH, 32'h0000_1100, 0, NO_FLAGS);
        add_op(OP_EXPECT, 32'h0000_1100, 32'h0000_1400, TAKEN);
        add_op(OP_EXPECT, 32'h0000_1400, 32'h0000_1410, NO_FLAGS);
        add_op(OP_END, 2, 0, NO_FLAGS);

        // counter 1 to 2, then back to 1
        add_op(OP_UPDATE, 32'h0000_1200, 32'h0000_1800, COND | TAKEN);
        add_op(OP_SQUASH, 32'h0000_1200, 0, NO_FLAGS);
        add_op(OP_EXPECT, 32'h0000_1200, 32'h0000_1210, NO_FLAGS);
        add_op(OP_EXPECT, 32'h0000_1200, 32'h0000_1800, TAKEN | OVERRIDE);
        add_op(OP_EXPECT, 32'h0000_1800, 32'h0000_1810, NO_FLAGS);
        add_op(OP_UPDATE, 32'h0000_1200, 32'h0000_1800, COND);
        add_op(OP_SQUASH, 32'h0000_1200, 0, NO_FLAGS);
        add_op(OP_EXPECT, 32'h0000_1200, 32'h0000_1210, NO_FLAGS);
        add_op(OP_EXPECT, 32'h0000_1210, 32'h0000_1220, NO_FLAGS);
        add_op(OP_END, 3, 0, NO_FLAGS);

        add_op(OP_STALL, 2, 0, NO_FLAGS);
        add_op(OP_SQUASH, 32'h0000_2400, 0, NO_FLAGS);
        add_op(OP_STALL, 2, 0, NO_FLAGS);
        add_op(OP_EXPECT, 32'h0000_2400, 32'h0000_2410, NO_FLAGS);
        add_csr(OP_WRITE, CSR_START_PC, 32'h0000_3000, NO_FLAGS);
        add_op(OP_STALL, 1, 0, NO_FLAGS);
        add_op(OP_EXPECT, 32'h0000_3000, 32'h0000_3010, NO_FLAGS);
        add_csr(OP_READ, CSR_START_PC, 32'h0000_3000, NO_FLAGS);
        add_op(OP_END, 4, 0, NO_FLAGS);

        add_op(OP_FILL, 8, 0, NO_FLAGS);
        add_op(OP_END, 5, 0, NO_FLAGS);

        add_op(OP_COUNTS, 0, 0, NO_FLAGS);
        add_op(OP_END, 6, 0, NO_FLAGS);
    endfunction

    initial begin : watchdog
        int cycles;
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        op_t op;
        seed          = 32'h7e58_4455;
        errors        = 0;
        checks        = 0;
        test_errors   = 0;
        tests_run     = 0;
        tests_failed  = 0;
        exp_preds     = 0;
        exp_overrides = 0;
        cycle_limit   = 0;
        drive_idle();
        rst = 1'b1;
        reset_model();
        build_table();
        cycle_limit = ops.size() * 20 + 10;

        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        for (int i = 0; i < ops.size(); i++) begin
            op = ops[i];
            case (op.kind)
                OP_WRITE:  transfer_csr(1'b1, op.a[7:0], op.b, op.f[0]);
                OP_READ:   transfer_csr(1'b0, op.a[7:0], op.b, op.f[0]);
                OP_UPDATE: send_update(op.a, op.b, op.f[1], op.f[0]);
                OP_SQUASH: squash_to(op.a);
                OP_STALL:  hold_stalled(op.a);
                OP_EXPECT: expect_pred(op.a, op.b, op.f[0], op.f[1]);
                OP_FILL:   fill_random(op.a);
                OP_COUNTS: begin
                    transfer_csr(1'b0, CSR_PRED_CNT, exp_preds, 1'b0);
                    transfer_csr(1'b0, CSR_REDIR_CNT, exp_overrides, 1'b0);
                end
                default:   finish_test(op.a);
            endcase
        end

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
hdl/bpu_pkg.sv
hdl/bpu_ubtb.sv
hdl/bpu_btb.sv
hdl/bpu_bimodal.sv
hdl/bpu_s2_resolve.sv
hdl/bpu_csr.sv
hdl/branch_predictor.sv
verification/branch_predictor_tb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= branch_predictor_tb
RTL_TOP   ?= branch_predictor
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
